// File: files.f
+incdir+include
source/tlp_pkg.sv
source/axis_skid_buffer.sv
source/tlp_hdr_merge.sv
source/tlp_merge_top.sv
verif/tb_tlp_merge.sv

// File: Makefile
# Verilator simulation of the TLP header merge testbench

.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal -f files.f --top-module tb_tlp_merge \
		--Mdir obj_dir -o sim_tb
	./obj_dir/sim_tb | tee sim.log
	grep -q "^Test passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: verif/tb_tlp_merge.sv
/*
 * Self-checking testbench for the TLP header merge path
 * Random packets go in on the header and payload streams with random gaps,
 * the sink stalls at random, and every output beat is compared with a
 * reference queue built from the header-plus-payload byte stream
 */

`timescale 1ns/10ps
`default_nettype none

`include "tlp_consts.svh"

module tb_tlp_merge;

    localparam int NUM_PKTS       = 200;
    localparam int TIMEOUT_CYCLES = NUM_PKTS * 40;

    logic                   clk;
    logic                   rst_n;
    logic                   hdr_valid;
    logic                   hdr_ready;
    tlp_pkg::tlp_hdr_t      hdr;
    logic [`TLP_USER_W-1:0] hdr_user;
    logic                   pld_valid;
    logic                   pld_ready;
    logic [`TLP_DATA_W-1:0] pld_data;
    logic [`TLP_KEEP_W-1:0] pld_keep;
    logic                   pld_last;
    logic                   tlp_valid;
    logic                   tlp_ready;
    logic [`TLP_DATA_W-1:0] tlp_data;
    logic [`TLP_KEEP_W-1:0] tlp_keep;
    logic                   tlp_last;
    logic [`TLP_USER_W-1:0] tlp_user;

    // Packet contents, generated before reset is released
    tlp_pkg::tlp_hdr_t      hdr_mem [NUM_PKTS];
    logic [`TLP_USER_W-1:0] user_mem [NUM_PKTS];
    logic [7:0]             byte_mem [NUM_PKTS][64];
    int                     len_mem [NUM_PKTS];
    int                     hdr_gap [NUM_PKTS];
    int                     pld_gap [NUM_PKTS];

    tlp_pkg::tlp_beat_t     want_q [$];

    integer seed = 32'hcc9a46e3;
    int     cycles = 0;
    int     value_errors = 0;
    int     stream_errors = 0;
    int     pkts_out = 0;
    int     beat_idx = 0;
    int     first_in_edge = 0;
    logic   first_out_seen = 1'b0;

    tlp_merge_top DUT (
        .clk(clk), .rst_n(rst_n),
        .hdr_valid(hdr_valid), .hdr_ready(hdr_ready), .hdr(hdr), .hdr_user(hdr_user),
        .pld_valid(pld_valid), .pld_ready(pld_ready), .pld_data(pld_data),
        .pld_keep(pld_keep), .pld_last(pld_last),
        .tlp_valid(tlp_valid), .tlp_ready(tlp_ready), .tlp_data(tlp_data),
        .tlp_keep(tlp_keep), .tlp_last(tlp_last), .tlp_user(tlp_user)
    );

    task automatic check_value(input string name, input logic [127:0] want,
                               input logic [127:0] got);
        if (want !== got)
        begin
            value_errors++;
            $display("Error %s: expected %h, actual %h", name, want, got);
        end
    endtask

    // The output is the header bytes followed by the payload bytes, cut into
    // whole beats; only the first beat carries the user bits
    task automatic build_expected(input int p);
        logic [7:0]         stream [0:71];
        tlp_pkg::tlp_beat_t beat;
        int                 total;
        int                 b;
        int                 k;
        total = 8 + len_mem[p];
        for (k = 0; k < 8; k++)
            stream[k] = hdr_mem[p][8*k +: 8];
        for (k = 0; k < len_mem[p]; k++)
            stream[8+k] = byte_mem[p][k];
        for (b = 0; b * 16 < total; b++)
        begin
            beat = '0;
            for (k = 0; k < 16; k++)
            begin
                if (b * 16 + k < total)
                begin
                    beat.data[8*k +: 8] = stream[b*16+k];
                    beat.keep[k]        = 1'b1;
                end
            end
            beat.last = ((b + 1) * 16 >= total);
            beat.user = (b == 0) ? user_mem[p] : '0;
            want_q.push_back(beat);
        end
    endtask

    task automatic compare_beat();
        tlp_pkg::tlp_beat_t want;
        string              tag;
        if (!first_out_seen)
        begin
            // The first packet enters from idle with the sink always ready
            first_out_seen = 1'b1;
            check_value("first beat latency", 128'(2), 128'(cycles + 1 - first_in_edge));
        end
        if (want_q.size() == 0)
        begin
            stream_errors++;
            $display("An extra output beat came out at cycle %0d", cycles);
            return;
        end
        want = want_q.pop_front();
        tag  = $sformatf("pkt %0d beat %0d", pkts_out, beat_idx);
        check_value({tag, " data"}, 128'(want.data), 128'(tlp_data));
        check_value({tag, " keep"}, 128'(want.keep), 128'(tlp_keep));
        check_value({tag, " last"}, 128'(want.last), 128'(tlp_last));
        check_value({tag, " user"}, 128'(want.user), 128'(tlp_user));
        if (want.last)
        begin
            pkts_out++;
            beat_idx = 0;
        end
        else
            beat_idx++;
    endtask

    // ==============================
    // Clock, reset and run control
    // ==============================
    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial
    begin
        while (cycles < TIMEOUT_CYCLES)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: only %0d of %0d packets came out", pkts_out, NUM_PKTS);
        $display("Test failed");
        $finish;
    end

    initial
    begin
        int r;
        rst_n = 1'b0;
        for (int i = 0; i < NUM_PKTS; i++)
        begin
            r = $random(seed);
            hdr_mem[i] = {$random(seed), $random(seed)};
            hdr_mem[i].fmt_type[6] = r[0];
            // Header-only packets still send one payload beat with byte 0 kept
            len_mem[i] = r[0] ? 1 + ({$random(seed)} % 64) : 1;
            hdr_mem[i].length = r[0] ? 10'((len_mem[i] + 3) / 4) : 10'd0;
            user_mem[i] = r[15:8];
            hdr_gap[i] = (i == 0) ? 0 : {$random(seed)} % 4;
            pld_gap[i] = (i == 0) ? 0 : {$random(seed)} % 4;
            for (int k = 0; k < 64; k++)
            begin
                r = $random(seed);
                byte_mem[i][k] = r[7:0];
            end
            build_expected(i);
        end
        repeat (3) @(posedge clk);
        #1 rst_n = 1'b1;
        @(negedge clk);
        check_value("reset tlp_valid", 128'(0), 128'(tlp_valid));
        check_value("reset hdr_ready", 128'(1), 128'(hdr_ready));
        check_value("reset pld_ready", 128'(1), 128'(pld_ready));
        wait (pkts_out == NUM_PKTS);
        // Leave room for any beat that should not be there
        repeat (20) @(posedge clk);
        $display("Closing count: %0d value errors, %0d stream errors",
                 value_errors, stream_errors);
        if (value_errors + stream_errors == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

    // ==============================
    // Producers, sink and monitor
    // ==============================
    initial
    begin
        hdr_valid = 1'b0;
        hdr       = '0;
        hdr_user  = '0;
        wait (rst_n === 1'b1);
        for (int i = 0; i < NUM_PKTS; i++)
        begin
            repeat (hdr_gap[i])
            begin
                @(posedge clk);
                #1;
            end
            hdr_valid = 1'b1;
            hdr       = hdr_mem[i];
            hdr_user  = user_mem[i];
            // Ready is a flop, so its value at the falling edge holds at the rising edge
            @(negedge clk);
            while (!hdr_ready) @(negedge clk);
            if (i == 0)
                first_in_edge = cycles + 1;
            @(posedge clk);
            #1 hdr_valid = 1'b0;
        end
    end

    initial
    begin
        int nbeats;
        pld_valid = 1'b0;
        pld_data  = '0;
        pld_keep  = '0;
        pld_last  = 1'b0;
        wait (rst_n === 1'b1);
        for (int i = 0; i < NUM_PKTS; i++)
        begin
            repeat (pld_gap[i])
            begin
                @(posedge clk);
                #1;
            end
            nbeats = (len_mem[i] + 15) / 16;
            for (int b = 0; b < nbeats; b++)
            begin
                pld_valid = 1'b1;
                pld_data  = '0;
                pld_keep  = '0;
                for (int k = 0; k < 16; k++)
                begin
                    if (b * 16 + k < len_mem[i])
                    begin
                        pld_data[8*k +: 8] = byte_mem[i][b*16+k];
                        pld_keep[k]        = 1'b1;
                    end
                end
                pld_last = (b == nbeats - 1);
                @(negedge clk);
                while (!pld_ready) @(negedge clk);
                @(posedge clk);
                #1;
            end
            pld_valid = 1'b0;
        end
    end

    // Sink stays ready until the first beat is out, then stalls at random
    initial
    begin
        int r;
        tlp_ready = 1'b1;
        wait (first_out_seen);
        forever
        begin
            @(posedge clk);
            r = $random(seed);
            #1 tlp_ready = r[0];
        end
    end

    initial
    begin
        forever
        begin
            @(negedge clk);
            if (rst_n && tlp_valid && tlp_ready)
                compare_beat();
        end
    end

endmodule

`default_nettype wire

// File: source/tlp_merge_top.sv
/*
 * Top level of the TLP header merge path
 * Takes a header stream and a bus-aligned payload stream on loose ports and
 * returns one TLP stream with inline headers
 * Pipeline is input skid buffers, merge stage and an output skid buffer
 */

`timescale 1ns/10ps
`default_nettype none

`include "tlp_consts.svh"

module tlp_merge_top (
    input  wire logic                   clk,
    input  wire logic                   rst_n,

    input  wire logic                   hdr_valid,
    output logic                        hdr_ready,
    input  tlp_pkg::tlp_hdr_t           hdr,
    input  wire logic [`TLP_USER_W-1:0] hdr_user,

    input  wire logic                   pld_valid,
    output logic                        pld_ready,
    input  wire logic [`TLP_DATA_W-1:0] pld_data,
    input  wire logic [`TLP_KEEP_W-1:0] pld_keep,
    input  wire logic                   pld_last,

    output logic                        tlp_valid,
    input  wire logic                   tlp_ready,
    output logic [`TLP_DATA_W-1:0]      tlp_data,
    output logic [`TLP_KEEP_W-1:0]      tlp_keep,
    output logic                        tlp_last,
    output logic [`TLP_USER_W-1:0]      tlp_user
);

    // Beats as they arrive on the loose ports
    tlp_pkg::hdr_beat_t hdr_in_beat;
    tlp_pkg::pld_beat_t pld_in_beat;

    // Registered inputs into the merge stage
    logic               hdr_q_valid;
    logic               hdr_q_ready;
    tlp_pkg::hdr_beat_t hdr_q_beat;
    logic               pld_q_valid;
    logic               pld_q_ready;
    tlp_pkg::pld_beat_t pld_q_beat;

    // Merged stream before the output register
    logic               mrg_valid;
    logic               mrg_ready;
    tlp_pkg::tlp_beat_t mrg_beat;

    tlp_pkg::tlp_beat_t tlp_out_beat;

    assign hdr_in_beat = '{hdr: hdr, user: hdr_user};
    assign pld_in_beat = '{data: pld_data, keep: pld_keep, last: pld_last};

    axis_skid_buffer #(.T(tlp_pkg::hdr_beat_t)) hdr_skid (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (hdr_valid),
        .in_ready  (hdr_ready),
        .in_beat   (hdr_in_beat),
        .out_valid (hdr_q_valid),
        .out_ready (hdr_q_ready),
        .out_beat  (hdr_q_beat)
    );

    axis_skid_buffer #(.T(tlp_pkg::pld_beat_t)) pld_skid (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (pld_valid),
        .in_ready  (pld_ready),
        .in_beat   (pld_in_beat),
        .out_valid (pld_q_valid),
        .out_ready (pld_q_ready),
        .out_beat  (pld_q_beat)
    );

    tlp_hdr_merge merge (
        .clk       (clk),
        .rst_n     (rst_n),
        .hdr_valid (hdr_q_valid),
        .hdr_ready (hdr_q_ready),
        .hdr_beat  (hdr_q_beat),
        .pld_valid (pld_q_valid),
        .pld_ready (pld_q_ready),
        .pld_beat  (pld_q_beat),
        .tlp_valid (mrg_valid),
        .tlp_ready (mrg_ready),
        .tlp_beat  (mrg_beat)
    );

    // Registered ready here keeps the merge stage free of long sink paths
    axis_skid_buffer #(.T(tlp_pkg::tlp_beat_t)) out_skid (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (mrg_valid),
        .in_ready  (mrg_ready),
        .in_beat   (mrg_beat),
        .out_valid (tlp_valid),
        .out_ready (tlp_ready),
        .out_beat  (tlp_out_beat)
    );

    assign tlp_data = tlp_out_beat.data;
    assign tlp_keep = tlp_out_beat.keep;
    assign tlp_last = tlp_out_beat.last;
    assign tlp_user = tlp_out_beat.user;

endmodule

`default_nettype wire

// File: source/tlp_hdr_merge.sv
/*
 * Merge stage that puts each TLP header in front of its payload
 * The header takes the low half of the first beat and the payload moves up
 * by half a bus, so every later beat joins the carried upper half of the
 * previous payload beat with the new lower half
 * A remainder left after the last payload beat goes out as a flush beat
 */

`timescale 1ns/10ps
`default_nettype none

`include "tlp_consts.svh"

module tlp_hdr_merge (
    input  wire logic         clk,
    input  wire logic         rst_n,

    input  wire logic         hdr_valid,
    output logic              hdr_ready,
    input  tlp_pkg::hdr_beat_t hdr_beat,

    input  wire logic         pld_valid,
    output logic              pld_ready,
    input  tlp_pkg::pld_beat_t pld_beat,

    output logic              tlp_valid,
    input  wire logic         tlp_ready,
    output tlp_pkg::tlp_beat_t tlp_beat
);

    localparam int HALF_W      = `TLP_DATA_W / 2;
    localparam int HALF_KEEP_W = `TLP_KEEP_W / 2;

    // Next payload beat begins a new packet
    logic is_sop;

    // Upper half of the previous payload beat, waiting for its slot
    logic                   carry_valid;
    logic [HALF_W-1:0]      carry_data;
    logic [HALF_KEEP_W-1:0] carry_keep;

    // Packet fits in the start beat together with its header
    logic single_beat;

    // Output transfer into the next stage
    logic tlp_xfer;

    // No data, or nothing in the upper half of the first payload beat
    assign single_beat = !tlp_pkg::has_data(hdr_beat.hdr) ||
                         !pld_beat.keep[HALF_KEEP_W];

    assign tlp_xfer = tlp_valid && tlp_ready;

    // ==============================
    // Handshake
    // ==============================

    // A header goes with the first payload beat of its packet, and only
    // once any remainder of the packet before it has been flushed
    assign hdr_ready = hdr_valid && pld_valid && tlp_ready &&
                       is_sop && !carry_valid;

    // Payload beats of a running packet flow whenever the output can take
    // them; a start beat also waits for its header and for the flush
    assign pld_ready = pld_valid && tlp_ready &&
                       (!is_sop || (hdr_valid && !carry_valid));

    // Output is either a payload-driven beat or a lone flush beat
    assign tlp_valid = pld_ready || (is_sop && carry_valid);

    // ==============================
    // Packet and carry tracking
    // ==============================
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            is_sop      <= 1'b1;
            carry_valid <= 1'b0;
        end
        else
        begin
            if (pld_valid && pld_ready)
            begin
                is_sop <= pld_beat.last;
            end

            if (tlp_xfer)
            begin
                if (pld_ready)
                begin
                    // Start beats leave a carry unless the packet fit;
                    // later beats leave one when their upper half had bytes
                    carry_valid <= is_sop ? !single_beat : pld_beat.keep[HALF_KEEP_W];
                end
                else
                begin
                    // Nothing consumed, so this transfer was the flush beat
                    carry_valid <= 1'b0;
                end
            end
        end
    end

    // The carry always holds the upper half of the latest payload beat;
    // after a flush carry_valid is low so stale contents are never used
    always_ff @(posedge clk)
    begin
        if (tlp_xfer)
        begin
            carry_data <= pld_beat.data[HALF_W +: HALF_W];
            carry_keep <= pld_beat.keep[HALF_KEEP_W +: HALF_KEEP_W];
        end
    end

    // ==============================
    // Output beat
    // ==============================
    always_comb
    begin
        if (hdr_ready)
        begin
            // Start beat: header low, first half of the payload high
            tlp_beat.data = {pld_beat.data[0 +: HALF_W], hdr_beat.hdr};
            tlp_beat.keep = {pld_beat.keep[0 +: HALF_KEEP_W], {HALF_KEEP_W{1'b1}}};
            tlp_beat.last = single_beat;
            tlp_beat.user = hdr_beat.user;
        end
        else
        begin
            tlp_beat.data = {pld_beat.data[0 +: HALF_W], carry_data};
            tlp_beat.keep = {pld_beat.keep[0 +: HALF_KEEP_W], carry_keep};

            // Flush beat carries the remainder only
            if (is_sop)
            begin
                tlp_beat.data[HALF_W +: HALF_W]           = '0;
                tlp_beat.keep[HALF_KEEP_W +: HALF_KEEP_W] = '0;
            end

            // An empty upper half means nothing spills into a flush beat
            tlp_beat.last = is_sop || !pld_beat.keep[HALF_KEEP_W];
            tlp_beat.user = '0;
        end
    end

endmodule

`default_nettype wire

// File: source/axis_skid_buffer.sv
/*
 * Two-entry skid buffer for a valid/ready stream of any payload type
 * Ready toward the source comes straight from a flop, so long ready paths
 * are cut while full throughput is kept
 * Set T to the beat struct that this stage boundary carries
 */

`timescale 1ns/10ps
`default_nettype none

module axis_skid_buffer #(
    parameter type T = logic [7:0]
) (
    input  wire logic clk,
    input  wire logic rst_n,

    input  wire logic in_valid,
    output logic      in_ready,
    input  T          in_beat,

    output logic      out_valid,
    input  wire logic out_ready,
    output T          out_beat
);

    // Main register drives the output, skid register catches the beat
    // that was already in flight when the output stalled
    logic main_valid;
    T     main_beat;
    logic skid_valid;
    T     skid_beat;

    // Main register may take a new beat when it is empty or draining
    logic main_load;
    // Skid register fills when a beat arrives while main is stuck
    logic skid_load;

    assign main_load = !main_valid || out_ready;
    assign skid_load = in_valid && in_ready && main_valid && !out_ready;

    // Only an empty skid register lets the source send, and skid_valid is a flop
    assign in_ready  = !skid_valid;
    assign out_valid = main_valid;
    assign out_beat  = main_beat;

    // ==============================
    // Control state
    // ==============================
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            main_valid <= 1'b0;
            skid_valid <= 1'b0;
        end
        else if (main_load)
        begin
            // A held skid beat goes first, else take whatever arrives now
            main_valid <= skid_valid || (in_valid && in_ready);
            skid_valid <= 1'b0;
        end
        else if (skid_load)
        begin
            skid_valid <= 1'b1;
        end
    end

    // ==============================
    // Payload registers
    // ==============================
    always_ff @(posedge clk)
    begin
        if (main_load)
        begin
            main_beat <= skid_valid ? skid_beat : in_beat;
        end

        if (skid_load)
        begin
            skid_beat <= in_beat;
        end
    end

endmodule

`default_nettype wire

// File: source/tlp_pkg.sv
/*
 * Shared types for the TLP header merge path
 * Holds the header layout, the beat structs passed between pipeline stages
 * and a helper that says whether a header announces a payload
 * Other files refer to these by scoped names
 */

`default_nettype none

`include "tlp_consts.svh"

package tlp_pkg;

    // Packed TLP header, exactly half the data bus wide
    // The first field listed lands in the most significant bits
    typedef struct packed {
        logic [7:0]  fmt_type;
        logic [9:0]  length;
        logic [15:0] requester_id;
        logic [7:0]  tag;
        logic [5:0]  attr;
        logic [15:0] lower_addr;
    } tlp_hdr_t;

    // One beat of the header stream, header plus its sideband bits
    typedef struct packed {
        tlp_hdr_t              hdr;
        logic [`TLP_USER_W-1:0] user;
    } hdr_beat_t;

    // One beat of the raw payload stream, bus aligned
    typedef struct packed {
        logic [`TLP_DATA_W-1:0] data;
        logic [`TLP_KEEP_W-1:0] keep;
        logic                   last;
    } pld_beat_t;

    // One beat of the merged stream with the header inline
    typedef struct packed {
        logic [`TLP_DATA_W-1:0] data;
        logic [`TLP_KEEP_W-1:0] keep;
        logic                   last;
        logic [`TLP_USER_W-1:0] user;
    } tlp_beat_t;

    // Bit 6 of fmt_type marks a request or completion that carries data
    function automatic logic has_data(input tlp_hdr_t hdr);
        return hdr.fmt_type[6];
    endfunction

endpackage

`default_nettype wire

// File: include/tlp_consts.svh
/*
 * Width constants for the TLP header merge path
 * Included by the package and by every module that sizes a bus or a beat
 * The header is exactly half the data bus and the merge logic relies on it
 */

`ifndef TLP_CONSTS_SVH
`define TLP_CONSTS_SVH

// Width of one stream beat in bits
`define TLP_DATA_W 128

// A TLP header fills exactly the low half of a beat
`define TLP_HDR_W 64

// One keep bit per byte of the data bus
`define TLP_KEEP_W 16

// Sideband user bits that travel with the header beat only
`define TLP_USER_W 8

`endif
